//--- hdl/cache_pkg.sv
package cache_pkg;

    // address and block geometry
    localparam int ADDR_WIDTH  = 16;
    localparam int OFFSET_BITS = 3;
    localparam int BLOCK_BYTES = 1 << OFFSET_BITS;

    // byte address seen by cores and memory
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // load/store datum, one byte
    typedef logic [7:0] byte_t;

    // one cache block, byte k sits in bits [8k+7:8k]
    typedef logic [8*BLOCK_BYTES-1:0] block_t;

    // byte position inside a block
    typedef logic [OFFSET_BITS-1:0] offset_t;

    // selects cache 0 or cache 1 at the arbiter
    typedef logic core_id_t;

    // cache controller
    // IDLE       takes core requests, serves hits directly
    // FILL_WAIT  read miss out on the bus, waiting for the block
    // STORE_WAIT write-through out on the bus, waiting for ack
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        FILL_WAIT  = 2'd1,
        STORE_WAIT = 2'd2
    } cache_state_t;

endpackage

//--- hdl/bus_ifs.sv
// cache to arbiter link, one per cache
// req and ack are single-cycle strobes
// inv is a snoop strobe from the arbiter, inv_addr valid with it
interface cache_bus_if import cache_pkg::*;;

    logic   req;
    logic   write;
    addr_t  addr;
    byte_t  wdata;
    logic   ack;
    block_t rdata;
    logic   inv;
    addr_t  inv_addr;

    modport cache (
        output req, write, addr, wdata,
        input  ack, rdata, inv, inv_addr
    );

    modport arb (
        input  req, write, addr, wdata,
        output ack, rdata, inv, inv_addr
    );

endinterface

// arbiter to backing memory link
// one transaction in flight at a time
interface mem_if import cache_pkg::*;;

    logic   req;
    logic   write;
    addr_t  addr;
    byte_t  wdata;
    logic   ack;
    block_t rdata;

    modport master (
        output req, write, addr, wdata,
        input  ack, rdata
    );

    modport slave (
        input  req, write, addr, wdata,
        output ack, rdata
    );

endinterface

//--- hdl/set_assoc_cache.sv
module set_assoc_cache import cache_pkg::*; #(
    parameter int         NUM_SETS  = 16,
    parameter logic [7:0] LFSR_SEED = 8'h01
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       req,
    input  logic       write,
    input  addr_t      addr,
    input  byte_t      wdata,
    output logic       done,
    output byte_t      rdata,
    output logic       hit,
    cache_bus_if.cache bus
);

    localparam int SET_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - OFFSET_BITS;

    typedef logic [SET_BITS-1:0] set_idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    // per-way storage indexed by set
    tag_t                tag_arr  [2][NUM_SETS];
    block_t              data_arr [2][NUM_SETS];
    logic [NUM_SETS-1:0] valid_arr [2];

    cache_state_t state;
    addr_t        op_addr;
    byte_t        op_wdata;
    logic         op_hit;
    logic         fill_stale;
    logic [7:0]   lfsr;

    set_idx_t req_set;
    set_idx_t op_set;
    set_idx_t inv_set;
    tag_t     req_tag;
    tag_t     op_tag;
    tag_t     inv_tag;
    offset_t  req_off;
    offset_t  op_off;
    logic [1:0] way_hit;
    logic     hit_any;
    logic     hit_way;
    logic     snoop_hits_op;
    logic     fill_en;
    logic     fill_way;
    logic     lfsr_step;
    logic     store_hit_en;
    block_t   merged;

    // field split of core, pending and snoop addresses
    assign req_off = addr[OFFSET_BITS-1:0];
    assign req_set = addr[OFFSET_BITS +: SET_BITS];
    assign req_tag = addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign op_off  = op_addr[OFFSET_BITS-1:0];
    assign op_set  = op_addr[OFFSET_BITS +: SET_BITS];
    assign op_tag  = op_addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign inv_set = bus.inv_addr[OFFSET_BITS +: SET_BITS];
    assign inv_tag = bus.inv_addr[ADDR_WIDTH-1 -: TAG_BITS];

    // compare both ways against the incoming request
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_arr[w][req_set] && (tag_arr[w][req_set] == req_tag);
        end
    end

    assign hit_any = |way_hit;
    // at most one way matches so way 1 flag names the way
    assign hit_way = way_hit[1];

    // store hit merges the byte into the cached block
    always_comb begin
        merged = data_arr[hit_way][req_set];
        merged[{req_off, 3'b000} +: 8] = wdata;
    end
    assign store_hit_en = (state == IDLE) && req && write && hit_any;

    // a write to our own outstanding block makes the returned data stale
    assign snoop_hits_op = bus.inv &&
        (bus.inv_addr[ADDR_WIDTH-1:OFFSET_BITS] == op_addr[ADDR_WIDTH-1:OFFSET_BITS]);
    assign fill_en = (state == FILL_WAIT) && bus.ack && !fill_stale && !snoop_hits_op;

    // victim is the lowest invalid way, else lfsr bit 0
    always_comb begin
        lfsr_step = 1'b0;
        if (!valid_arr[0][op_set]) begin
            fill_way = 1'b0;
        end else if (!valid_arr[1][op_set]) begin
            fill_way = 1'b1;
        end else begin
            fill_way  = lfsr[0];
            lfsr_step = fill_en;
        end
    end

    // bus request fields held from the request cycle until ack
    assign bus.addr  = op_addr;
    assign bus.wdata = op_wdata;
    assign bus.write = (state == STORE_WAIT);

    // tag and data arrays, pending request and response payload
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_arr[fill_way][op_set]  <= op_tag;
            data_arr[fill_way][op_set] <= bus.rdata;
        end
        if (store_hit_en) begin
            data_arr[hit_way][req_set] <= merged;
        end
        if (state == IDLE && req) begin
            op_addr  <= addr;
            op_wdata <= wdata;
            op_hit   <= hit_any;
            // only used when this turns out to be a read hit
            rdata    <= data_arr[hit_way][req_set][{req_off, 3'b000} +: 8];
            hit      <= 1'b1;
        end
        if (state == FILL_WAIT && bus.ack) begin
            rdata <= bus.rdata[{op_off, 3'b000} +: 8];
            hit   <= 1'b0;
        end
        if (state == STORE_WAIT && bus.ack) begin
            rdata <= op_wdata;
            hit   <= op_hit;
        end
    end

    // controller, valid bits and replacement lfsr
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            bus.req      <= 1'b0;
            done         <= 1'b0;
            fill_stale   <= 1'b0;
            lfsr         <= LFSR_SEED;
            valid_arr[0] <= '0;
            valid_arr[1] <= '0;
        end else begin
            bus.req <= 1'b0;
            done    <= 1'b0;
            // x^8+x^6+x^5+x^4+1 in galois form
            // msb wraps into bit 0 and flips taps 6, 5 and 4
            if (lfsr_step) begin
                lfsr <= {lfsr[6:0], lfsr[7]} ^ {1'b0, {3{lfsr[7]}}, 4'b0000};
            end
            case (state)
                IDLE: begin
                    if (req) begin
                        if (write) begin
                            state   <= STORE_WAIT;
                            bus.req <= 1'b1;
                        end else if (hit_any) begin
                            done <= 1'b1;
                        end else begin
                            state      <= FILL_WAIT;
                            bus.req    <= 1'b1;
                            fill_stale <= 1'b0;
                        end
                    end
                end
                FILL_WAIT: begin
                    if (snoop_hits_op) begin
                        fill_stale <= 1'b1;
                    end
                    if (bus.ack) begin
                        done  <= 1'b1;
                        state <= IDLE;
                        if (fill_en) begin
                            valid_arr[fill_way][op_set] <= 1'b1;
                        end
                    end
                end
                STORE_WAIT: begin
                    if (bus.ack) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            // snoop invalidate applies in any state
            for (int w = 0; w < 2; w++) begin
                if (bus.inv && valid_arr[w][inv_set] && (tag_arr[w][inv_set] == inv_tag)) begin
                    valid_arr[w][inv_set] <= 1'b0;
                end
            end
        end
    end

    // core must wait for done before the next request
    assert property (@(posedge clk) disable iff (reset) (state != IDLE) |-> !req)
        else $error("core request while cache is busy");

    // fills never duplicate a block across ways
    assert property (@(posedge clk) disable iff (reset) req |-> !(way_hit[0] && way_hit[1]))
        else $error("block present in both ways");

endmodule

//--- hdl/mem_arbiter.sv
module mem_arbiter import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    cache_bus_if.arb c0,
    cache_bus_if.arb c1,
    mem_if.master    mem
);

    logic     pend0;
    logic     pend1;
    logic     want0;
    logic     want1;
    logic     busy;
    logic     can_grant;
    logic     grant;
    core_id_t owner;
    core_id_t prio;
    core_id_t sel;

    // pending request per cache, including one arriving this cycle
    assign want0 = pend0 | c0.req;
    assign want1 = pend1 | c1.req;

    // memory free, or freeing up on this ack
    assign can_grant = !busy || mem.ack;
    assign grant     = can_grant && (want0 || want1);

    // round robin only matters when both are waiting
    always_comb begin
        if (want0 && want1) begin
            sel = prio;
        end else begin
            sel = want1 ? 1'b1 : 1'b0;
        end
    end

    // ack and block go straight back to the owner
    assign c0.ack   = mem.ack && busy && (owner == 1'b0);
    assign c1.ack   = mem.ack && busy && (owner == 1'b1);
    assign c0.rdata = mem.rdata;
    assign c1.rdata = mem.rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            pend0   <= 1'b0;
            pend1   <= 1'b0;
            busy    <= 1'b0;
            owner   <= 1'b0;
            prio    <= 1'b0;
            mem.req <= 1'b0;
            c0.inv  <= 1'b0;
            c1.inv  <= 1'b0;
        end else begin
            mem.req <= grant;
            c0.inv  <= 1'b0;
            c1.inv  <= 1'b0;
            pend0   <= want0 && !(grant && sel == 1'b0);
            pend1   <= want1 && !(grant && sel == 1'b1);
            if (grant) begin
                busy  <= 1'b1;
                owner <= sel;
                prio  <= ~sel;
                // granted write snoops the other cache
                if (sel == 1'b0) begin
                    c1.inv <= c0.write;
                end else begin
                    c0.inv <= c1.write;
                end
            end else if (mem.ack) begin
                busy <= 1'b0;
            end
        end
    end

    // request fields and snoop addresses, captured at grant
    always_ff @(posedge clk) begin
        if (grant) begin
            mem.addr    <= sel ? c1.addr : c0.addr;
            mem.write   <= sel ? c1.write : c0.write;
            mem.wdata   <= sel ? c1.wdata : c0.wdata;
            c0.inv_addr <= c1.addr;
            c1.inv_addr <= c0.addr;
        end
    end

    // memory answers only a granted request
    assert property (@(posedge clk) disable iff (reset) mem.ack |-> busy)
        else $error("memory ack with no grant active");

endmodule

//--- hdl/backing_mem.sv
module backing_mem import cache_pkg::*; #(
    // latency of at least 2 cycles
    parameter int MEM_LATENCY = 4
) (
    input  logic  clk,
    input  logic  reset,
    mem_if.slave  bus
);

    localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

    byte_t mem_arr [2**ADDR_WIDTH];

    addr_t               op_addr;
    logic                op_write;
    byte_t               op_wdata;
    logic                busy;
    logic [CNT_BITS-1:0] count;
    logic                fire;

    // last counting cycle, ack is registered here
    assign fire = busy && (count == CNT_BITS'(MEM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            count   <= '0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= fire;
            if (bus.req) begin
                busy  <= 1'b1;
                count <= CNT_BITS'(1);
            end else if (fire) begin
                busy <= 1'b0;
            end else if (busy) begin
                count <= count + 1'b1;
            end
        end
    end

    // contents at reset: low byte ^ high byte ^ 5a
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int a = 0; a < 2**ADDR_WIDTH; a++) begin
                mem_arr[a] <= a[7:0] ^ a[15:8] ^ 8'h5a;
            end
        end else if (fire && op_write) begin
            mem_arr[op_addr] <= op_wdata;
        end
    end

    // request capture and aligned block read
    always_ff @(posedge clk) begin
        if (bus.req) begin
            op_addr  <= bus.addr;
            op_write <= bus.write;
            op_wdata <= bus.wdata;
        end
        if (fire && !op_write) begin
            for (int k = 0; k < BLOCK_BYTES; k++) begin
                bus.rdata[8*k +: 8] <= mem_arr[{op_addr[ADDR_WIDTH-1:OFFSET_BITS], offset_t'(k)}];
            end
        end
    end

    // arbiter keeps one transaction in flight
    assert property (@(posedge clk) disable iff (reset) busy |-> !bus.req)
        else $error("memory request while busy");

endmodule

//--- hdl/cache_subsystem_top.sv
module cache_subsystem_top import cache_pkg::*; #(
    parameter int NUM_SETS    = 16,
    parameter int MEM_LATENCY = 4
) (
    input  logic  clk,
    input  logic  reset,
    // core 0
    input  logic  c0_req,
    input  logic  c0_write,
    input  addr_t c0_addr,
    input  byte_t c0_wdata,
    output logic  c0_done,
    output byte_t c0_rdata,
    output logic  c0_hit,
    // core 1
    input  logic  c1_req,
    input  logic  c1_write,
    input  addr_t c1_addr,
    input  byte_t c1_wdata,
    output logic  c1_done,
    output byte_t c1_rdata,
    output logic  c1_hit
);

    cache_bus_if bus0 ();
    cache_bus_if bus1 ();
    mem_if       mbus ();

    // private caches, seeds differ so victims diverge
    set_assoc_cache #(
        .NUM_SETS  (NUM_SETS),
        .LFSR_SEED (8'h01)
    ) cache0 (
        .clk   (clk),
        .reset (reset),
        .req   (c0_req),
        .write (c0_write),
        .addr  (c0_addr),
        .wdata (c0_wdata),
        .done  (c0_done),
        .rdata (c0_rdata),
        .hit   (c0_hit),
        .bus   (bus0.cache)
    );

    set_assoc_cache #(
        .NUM_SETS  (NUM_SETS),
        .LFSR_SEED (8'h5b)
    ) cache1 (
        .clk   (clk),
        .reset (reset),
        .req   (c1_req),
        .write (c1_write),
        .addr  (c1_addr),
        .wdata (c1_wdata),
        .done  (c1_done),
        .rdata (c1_rdata),
        .hit   (c1_hit),
        .bus   (bus1.cache)
    );

    mem_arbiter arbiter (
        .clk   (clk),
        .reset (reset),
        .c0    (bus0.arb),
        .c1    (bus1.arb),
        .mem   (mbus.master)
    );

    backing_mem #(
        .MEM_LATENCY (MEM_LATENCY)
    ) memory (
        .clk   (clk),
        .reset (reset),
        .bus   (mbus.slave)
    );

endmodule

//--- verif/cache_tb.sv
module cache_tb import cache_pkg::*;;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    NUM_SETS    = 16;
    localparam int    MEM_LATENCY = 4;
    localparam string GOLDEN_FILE = "verif/cache_golden.txt";

    logic  clk;
    logic  reset;
    logic  c0_req;
    logic  c0_write;
    addr_t c0_addr;
    byte_t c0_wdata;
    logic  c0_done;
    byte_t c0_rdata;
    logic  c0_hit;
    logic  c1_req;
    logic  c1_write;
    addr_t c1_addr;
    byte_t c1_wdata;
    logic  c1_done;
    byte_t c1_rdata;
    logic  c1_hit;

    // golden operations with one entry per data line
    int       op_line  [$];
    int       op_group [$];
    core_id_t op_core  [$];
    logic     op_write [$];
    addr_t    op_addr  [$];
    byte_t    op_wdata [$];
    byte_t    op_rdata [$];
    logic     op_hit   [$];

    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;

    cache_subsystem_top #(
        .NUM_SETS    (NUM_SETS),
        .MEM_LATENCY (MEM_LATENCY)
    ) cache_subsystem_top_inst (
        .clk      (clk),
        .reset    (reset),
        .c0_req   (c0_req),
        .c0_write (c0_write),
        .c0_addr  (c0_addr),
        .c0_wdata (c0_wdata),
        .c0_done  (c0_done),
        .c0_rdata (c0_rdata),
        .c0_hit   (c0_hit),
        .c1_req   (c1_req),
        .c1_write (c1_write),
        .c1_addr  (c1_addr),
        .c1_wdata (c1_wdata),
        .c1_done  (c1_done),
        .c1_rdata (c1_rdata),
        .c1_hit   (c1_hit)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first failure");
    endtask

    // watchdog with a limit set once the golden file is loaded
    initial begin
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
                stop_with_failure($sformatf("timeout: done never arrived within %0d cycles",
                                            cycle_limit));
            end
        end
    end

    task automatic check_byte(input byte_t got, input byte_t expected, input string what);
        if (got !== expected) begin
            stop_with_failure($sformatf("[FAIL] %0t %s: rdata %h, expected %h",
                                        $time, what, got, expected));
        end
    endtask

    task automatic check_hit(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            stop_with_failure($sformatf("[FAIL] %0t %s: hit %b, expected %b",
                                        $time, what, got, expected));
        end
    endtask

    // stores return no load data so only the hit flag is compared
    task automatic check_result(input int idx, input byte_t got_data, input logic got_hit);
        string what;
        what = $sformatf("line %0d core %0d %s %h", op_line[idx], op_core[idx],
                         op_write[idx] ? "store" : "load", op_addr[idx]);
        if (!op_write[idx]) begin
            check_byte(got_data, op_rdata[idx], what);
        end
        check_hit(got_hit, op_hit[idx], what);
    endtask

    task automatic load_golden();
        int          fd;
        int          fields;
        int          line_no;
        string       line;
        int unsigned g, c, w, a, d, e, h;
        fd      = $fopen(GOLDEN_FILE, "r");
        line_no = 0;
        if (fd == 0) begin
            stop_with_failure({"could not open golden file ", GOLDEN_FILE});
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            // comment lines start with #
            if (line.len() > 0 && line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%d %d %d %h %h %h %d", g, c, w, a, d, e, h);
            if (fields == 7) begin
                op_line.push_back(line_no);
                op_group.push_back(int'(g));
                op_core.push_back(core_id_t'(c));
                op_write.push_back(w != 0);
                op_addr.push_back(addr_t'(a));
                op_wdata.push_back(byte_t'(d));
                op_rdata.push_back(byte_t'(e));
                op_hit.push_back(h != 0);
            end else if (fields > 0) begin
                stop_with_failure($sformatf("golden file line %0d is malformed", line_no));
            end
        end
        $fclose(fd);
    endtask

    // ops [first..last] share a group with at most one per core
    task automatic run_group(input int first, input int last);
        logic pend0;
        logic pend1;
        int   idx0;
        int   idx1;
        pend0 = 1'b0;
        pend1 = 1'b0;
        idx0  = 0;
        idx1  = 0;
        for (int i = first; i <= last; i++) begin
            if ((op_core[i] == 1'b0 && pend0) || (op_core[i] == 1'b1 && pend1)) begin
                stop_with_failure($sformatf("golden group %0d has two ops for one core",
                                            op_group[i]));
            end
            if (op_core[i] == 1'b0) begin
                pend0 = 1'b1;
                idx0  = i;
            end else begin
                pend1 = 1'b1;
                idx1  = i;
            end
        end
        // both cores raise req in the same cycle
        @(posedge clk);
        #1;
        if (pend0) begin
            c0_req   = 1'b1;
            c0_write = op_write[idx0];
            c0_addr  = op_addr[idx0];
            c0_wdata = op_wdata[idx0];
        end
        if (pend1) begin
            c1_req   = 1'b1;
            c1_write = op_write[idx1];
            c1_addr  = op_addr[idx1];
            c1_wdata = op_wdata[idx1];
        end
        @(posedge clk);
        #1;
        c0_req = 1'b0;
        c1_req = 1'b0;
        // done strobes are sampled mid-cycle
        while (pend0 || pend1) begin
            @(negedge clk);
            if (pend0 && c0_done) begin
                check_result(idx0, c0_rdata, c0_hit);
                pend0 = 1'b0;
            end
            if (pend1 && c1_done) begin
                check_result(idx1, c1_rdata, c1_hit);
                pend1 = 1'b0;
            end
        end
    endtask

    initial begin
        int first;
        int last;
        reset    = 1'b1;
        c0_req   = 1'b0;
        c0_write = 1'b0;
        c0_addr  = '0;
        c0_wdata = '0;
        c1_req   = 1'b0;
        c1_write = 1'b0;
        c1_addr  = '0;
        c1_wdata = '0;
        load_golden();
        // worst case per op is a contended miss plus issue overhead
        cycle_limit = op_group.size() * (2 * MEM_LATENCY + 8) + 100;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        first = 0;
        while (first < op_group.size()) begin
            last = first;
            while (last + 1 < op_group.size() && op_group[last + 1] == op_group[first]) begin
                last++;
            end
            run_group(first, last);
            first = last + 1;
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- verif/cache_golden.txt
# group core write addr(hex) wdata(hex) exp_rdata(hex) exp_hit
# same group number = issued to both cores in one cycle; stores carry exp_rdata 00
# cold miss, then hit in the same block
1 0 0 0010 00 4a 0
2 0 0 0013 00 49 1
# set 5 in cache 0, three tags, lfsr seed 01
3 0 0 0028 00 72 0
4 0 0 00a8 00 f2 0
5 0 0 0128 00 73 0
6 0 0 0029 00 73 1
7 0 0 00aa 00 f0 0
8 0 0 012b 00 70 1
9 0 0 0028 00 72 0
10 0 0 012f 00 74 1
# store hit, write-through seen by cache 1
11 0 0 0240 00 18 0
12 0 1 0243 c3 00 1
13 0 0 0243 00 c3 1
14 0 0 0242 00 1a 1
15 1 0 0243 00 c3 0
# store miss, no allocate
16 1 1 0318 77 00 0
17 1 0 0318 00 77 0
18 1 0 0319 00 40 1
# snoop invalidate of cache 0 by a cache 1 store
19 0 0 0405 00 5b 0
20 1 0 0406 00 58 0
21 1 1 0405 e1 00 1
22 0 0 0405 00 e1 0
23 1 0 0405 00 e1 1
# contention, both cores at once
24 0 0 0500 00 5f 0
24 1 0 0608 00 54 0
25 0 0 0700 00 5d 0
25 1 0 0701 00 5c 0
26 0 1 0808 3c 00 0
26 1 0 0a10 00 40 0
27 1 0 0808 00 3c 0
27 0 0 0507 00 58 1
28 0 0 0402 00 5c 0
28 1 0 060f 00 53 1
29 0 0 0703 00 5e 0
29 1 0 0703 00 5e 1
# concurrent stores, cache 0 store invalidates cache 1 line
30 0 1 0a11 99 00 0
30 1 1 0a12 aa 00 1
31 1 0 0a11 00 99 0
31 0 0 0a12 00 aa 0

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -Wno-fatal \
    --top-module cache_tb -o Vcache_tb \
    -f all.f

./obj_dir/Vcache_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
grep -q "TEST PASS" sim.log

//--- all.f
hdl/cache_pkg.sv
hdl/bus_ifs.sv
hdl/set_assoc_cache.sv
hdl/mem_arbiter.sv
hdl/backing_mem.sv
hdl/cache_subsystem_top.sv
verif/cache_tb.sv
